//--- hw/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// datapath widths
`define CSR_DATA_W 32
`define CSR_NUM_W  14

// exception code and subcode as they sit in ESTAT
`define ECODE_W    6
`define ESUBCODE_W 9

// interrupt lines and the ECFG.LIE field
`define HW_IRQ_N   8
`define LIE_W      13

// CRMD after reset, direct address mode with PLV0 and IE clear
`define CRMD_RESET 32'h0000_0008

`endif

//--- hw/csr_arch_pkg.sv
`default_nettype none

`include "csr_macros.svh"

package csr_arch_pkg;

    typedef logic [`CSR_DATA_W-1:0] csr_data_t;
    typedef logic [`CSR_NUM_W-1:0]  csr_num_t;
    typedef logic [`ECODE_W-1:0]    ecode_t;
    typedef logic [`ESUBCODE_W-1:0] esubcode_t;
    typedef logic [1:0]             plv_t;
    typedef logic [`LIE_W-1:0]      lie_t;

    typedef enum logic [`CSR_NUM_W-1:0] {
        CRMD   = 14'h00,
        PRMD   = 14'h01,
        ECFG   = 14'h04,
        ESTAT  = 14'h05,
        ERA    = 14'h06,
        EENTRY = 14'h0c,
        SAVE0  = 14'h30,
        SAVE1  = 14'h31,
        SAVE2  = 14'h32,
        SAVE3  = 14'h33,
        TID    = 14'h40,
        TCFG   = 14'h41,
        TVAL   = 14'h42,
        TICLR  = 14'h44
    } csr_addr_e;

    localparam ecode_t INT = 6'h00;
    localparam ecode_t SYS = 6'h0b;
    localparam ecode_t BRK = 6'h0c;
    localparam ecode_t INE = 6'h0d;

    // committed register fields as seen by the issue stage
    typedef struct packed {
        plv_t            crmd_plv;
        logic            crmd_ie;
        logic            crmd_da;
        plv_t            prmd_pplv;
        logic            prmd_pie;
        lie_t            ecfg_lie;
        logic [1:0]      estat_is_sw;
        ecode_t          estat_ecode;
        esubcode_t       estat_esubcode;
        csr_data_t       era;
        csr_data_t       eentry;
        csr_data_t [3:0] save;
        csr_data_t       tid;
        csr_data_t       tcfg;
        csr_data_t       tval;
        logic            ti;
    } csr_view_t;

endpackage

`default_nettype wire

//--- hw/csr_pipe_pkg.sv
`default_nettype none

package csr_pipe_pkg;

    typedef enum logic [2:0] {
        NONE    = 3'd0,
        CSRRD   = 3'd1,
        CSRWR   = 3'd2,
        CSRXCHG = 3'd3,
        ERTN    = 3'd4,
        EXCP    = 3'd5
    } csr_op_e;

    typedef struct packed {
        logic                   valid;
        csr_arch_pkg::ecode_t    ecode;
        csr_arch_pkg::esubcode_t esubcode;
    } excp_t;

    typedef struct packed {
        csr_op_e                op;
        csr_arch_pkg::csr_num_t  csr_num;
        csr_arch_pkg::csr_data_t wdata;
        csr_arch_pkg::csr_data_t wmask;
        csr_arch_pkg::csr_data_t pc;
    } csr_req_t;

    // issue to commit, wdata already merged under the mask
    typedef struct packed {
        csr_op_e                 op;
        csr_arch_pkg::csr_num_t  csr_num;
        csr_arch_pkg::csr_data_t wdata;
        csr_arch_pkg::ecode_t    ecode;
        csr_arch_pkg::esubcode_t esubcode;
        csr_arch_pkg::csr_data_t pc;
        logic                    taken;
    } csr_stage_t;

endpackage

`default_nettype wire

//--- hw/csr_timer.sv
`timescale 1ns/1ns
`default_nettype none

module csr_timer #(
    parameter int TIMER_W = 32
) (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    tcfg_wr,
    input  wire csr_arch_pkg::csr_data_t tcfg,
    input  wire logic                    ti_clr,
    output csr_arch_pkg::csr_data_t      tval,
    output logic                         ti
);

    logic               en;
    logic               periodic;
    logic [TIMER_W-1:0] init_val;
    logic [TIMER_W-1:0] cnt;
    logic               expired;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];
    assign init_val = {tcfg[TIMER_W-1:2], 2'b00};  // initval is word granular
    assign expired  = en && (cnt == '0) && !tcfg_wr;
    assign tval     = csr_arch_pkg::csr_data_t'(cnt);

    always_ff @(posedge clk)
    begin
        if (!rstn)
            cnt <= '0;
        else if (tcfg_wr)
            cnt <= init_val;
        else if (en)
        begin
            if (cnt == '0)
                cnt <= periodic ? init_val : '1;  // one-shot parks at all ones
            else if (cnt != '1)
                cnt <= cnt - TIMER_W'(1);
        end
    end

    // clear wins over a new expiry
    always_ff @(posedge clk)
    begin
        if (!rstn)
            ti <= 1'b0;
        else if (ti_clr)
            ti <= 1'b0;
        else if (expired)
            ti <= 1'b1;
    end

endmodule

`default_nettype wire

//--- hw/csr_issue.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_macros.svh"

module csr_issue (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire csr_pipe_pkg::csr_req_t   req,
    input  wire logic                     op_valid,
    input  wire csr_pipe_pkg::excp_t      excp,
    input  wire logic                     stall,
    input  wire logic                     flush,
    input  wire logic [`HW_IRQ_N-1:0]     hw_irq,
    input  wire csr_arch_pkg::csr_view_t  regs,
    output csr_pipe_pkg::csr_stage_t      stage,
    output csr_arch_pkg::csr_data_t       rdata,
    output logic                          redirect,
    output csr_arch_pkg::csr_data_t       redirect_pc
);

    csr_arch_pkg::lie_t       pend;
    logic                     excp_inflight;
    logic                     irq_take;
    logic                     accept;
    csr_pipe_pkg::csr_op_e    op;
    csr_arch_pkg::csr_data_t  rd_val;
    csr_arch_pkg::csr_data_t  wmask;
    csr_arch_pkg::csr_data_t  redir_pc_d;
    logic                     redir_d;
    csr_pipe_pkg::csr_stage_t stage_d;

    // same bit order as ESTAT.IS, bit 10 and IPI unused
    assign pend = {1'b0, regs.ti, 1'b0, hw_irq, regs.estat_is_sw} & regs.ecfg_lie;

    // hold off while an entry is still waiting to clear IE
    assign excp_inflight = stage.taken && (stage.op == csr_pipe_pkg::EXCP);
    assign irq_take      = regs.crmd_ie && (|pend) && !excp_inflight;
    assign accept        = (op_valid && !stall && !flush) || irq_take;

    assign op = (irq_take || excp.valid) ? csr_pipe_pkg::EXCP : req.op;

    always_comb
    begin
        case (req.csr_num)
            csr_arch_pkg::CRMD:   rd_val = {28'b0, regs.crmd_da, regs.crmd_ie, regs.crmd_plv};
            csr_arch_pkg::PRMD:   rd_val = {29'b0, regs.prmd_pie, regs.prmd_pplv};
            csr_arch_pkg::ECFG:   rd_val = {19'b0, regs.ecfg_lie};
            csr_arch_pkg::ESTAT:  rd_val = {1'b0, regs.estat_esubcode, regs.estat_ecode, 4'b0,
                                            regs.ti, 1'b0, hw_irq, regs.estat_is_sw};
            csr_arch_pkg::ERA:    rd_val = regs.era;
            csr_arch_pkg::EENTRY: rd_val = regs.eentry;
            csr_arch_pkg::SAVE0:  rd_val = regs.save[0];
            csr_arch_pkg::SAVE1:  rd_val = regs.save[1];
            csr_arch_pkg::SAVE2:  rd_val = regs.save[2];
            csr_arch_pkg::SAVE3:  rd_val = regs.save[3];
            csr_arch_pkg::TID:    rd_val = regs.tid;
            csr_arch_pkg::TCFG:   rd_val = regs.tcfg;
            csr_arch_pkg::TVAL:   rd_val = regs.tval;
            default:              rd_val = '0;  // TICLR reads zero
        endcase
    end

    assign wmask = (req.op == csr_pipe_pkg::CSRWR) ? '1 : req.wmask;

    always_comb
    begin
        redir_d    = 1'b1;
        redir_pc_d = req.pc + 32'd4;
        case (op)
            csr_pipe_pkg::EXCP:    redir_pc_d = regs.eentry;
            csr_pipe_pkg::ERTN:    redir_pc_d = regs.era;
            csr_pipe_pkg::CSRWR,
            csr_pipe_pkg::CSRXCHG: redir_d = 1'b1;
            default:               redir_d = 1'b0;
        endcase
    end

    always_comb
    begin
        stage_d          = '0;
        stage_d.op       = op;
        stage_d.csr_num  = req.csr_num;
        stage_d.wdata    = (req.wdata & wmask) | (rd_val & ~wmask);
        stage_d.ecode    = irq_take ? csr_arch_pkg::INT : excp.ecode;
        stage_d.esubcode = irq_take ? '0 : excp.esubcode;
        stage_d.pc       = req.pc;
        stage_d.taken    = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn || (flush && !irq_take))
        begin
            stage    <= '0;
            redirect <= 1'b0;
        end
        else if (accept)
        begin
            stage    <= stage_d;
            redirect <= redir_d;
        end
        else
        begin
            stage.taken <= 1'b0;  // fields hold, nothing to commit
            redirect    <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rdata       <= rd_val;  // old value
            redirect_pc <= redir_pc_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_macros.svh"

module csr_regfile (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire csr_pipe_pkg::csr_stage_t stage,
    input  wire csr_arch_pkg::csr_data_t  tval,
    input  wire logic                     ti,
    output csr_arch_pkg::csr_view_t       regs,
    output logic                          tcfg_wr,
    output csr_arch_pkg::csr_data_t       tcfg,
    output logic                          ti_clr,
    output logic                          excp_flush,
    output logic                          ertn_flush
);

    localparam csr_arch_pkg::csr_data_t crmd_rst  = `CRMD_RESET;
    localparam csr_arch_pkg::lie_t      lie_wmask = 13'h0bff;  // no bit 10, no IPI

    csr_arch_pkg::plv_t            crmd_plv;
    logic                          crmd_ie;
    logic                          crmd_da;
    csr_arch_pkg::plv_t            prmd_pplv;
    logic                          prmd_pie;
    csr_arch_pkg::lie_t            ecfg_lie;
    logic [1:0]                    estat_is_sw;
    csr_arch_pkg::ecode_t          estat_ecode;
    csr_arch_pkg::esubcode_t       estat_esubcode;
    csr_arch_pkg::csr_data_t       era;
    csr_arch_pkg::csr_data_t       eentry;
    csr_arch_pkg::csr_data_t [3:0] save;
    csr_arch_pkg::csr_data_t       tid;
    logic                          commit_excp;
    logic                          commit_ertn;
    logic                          commit_wr;

    assign commit_excp = stage.taken && (stage.op == csr_pipe_pkg::EXCP);
    assign commit_ertn = stage.taken && (stage.op == csr_pipe_pkg::ERTN);
    assign commit_wr   = stage.taken && (stage.op == csr_pipe_pkg::CSRWR ||
                                         stage.op == csr_pipe_pkg::CSRXCHG);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_plv    <= crmd_rst[1:0];
            crmd_ie     <= crmd_rst[2];
            crmd_da     <= crmd_rst[3];
            prmd_pplv   <= '0;
            prmd_pie    <= 1'b0;
            ecfg_lie    <= '0;
            estat_is_sw <= '0;
            tcfg        <= '0;
            excp_flush  <= 1'b0;
            ertn_flush  <= 1'b0;
            tcfg_wr     <= 1'b0;
            ti_clr      <= 1'b0;
        end
        else
        begin
            excp_flush <= commit_excp;
            ertn_flush <= commit_ertn;
            tcfg_wr    <= commit_wr && (stage.csr_num == csr_arch_pkg::TCFG);
            ti_clr     <= commit_wr && (stage.csr_num == csr_arch_pkg::TICLR) && stage.wdata[0];
            if (commit_excp)
            begin
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
                crmd_plv  <= '0;
                crmd_ie   <= 1'b0;
            end
            else if (commit_ertn)
            begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end
            else if (commit_wr)
            begin
                case (stage.csr_num)
                    csr_arch_pkg::CRMD:
                    begin
                        crmd_plv <= stage.wdata[1:0];  // DA stays
                        crmd_ie  <= stage.wdata[2];
                    end
                    csr_arch_pkg::PRMD:
                    begin
                        prmd_pplv <= stage.wdata[1:0];
                        prmd_pie  <= stage.wdata[2];
                    end
                    csr_arch_pkg::ECFG:  ecfg_lie    <= stage.wdata[12:0] & lie_wmask;
                    csr_arch_pkg::ESTAT: estat_is_sw <= stage.wdata[1:0];  // sw bits only
                    csr_arch_pkg::TCFG:  tcfg        <= stage.wdata;
                    default:             ;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (commit_excp)
        begin
            era            <= stage.pc;
            estat_ecode    <= stage.ecode;
            estat_esubcode <= stage.esubcode;
        end
        else if (commit_wr)
        begin
            case (stage.csr_num)
                csr_arch_pkg::ERA:    era    <= stage.wdata;
                csr_arch_pkg::EENTRY: eentry <= {stage.wdata[31:6], 6'b0};
                csr_arch_pkg::SAVE0,
                csr_arch_pkg::SAVE1,
                csr_arch_pkg::SAVE2,
                csr_arch_pkg::SAVE3:  save[stage.csr_num[1:0]] <= stage.wdata;
                csr_arch_pkg::TID:    tid    <= stage.wdata;
                default:              ;
            endcase
        end
    end

    always_comb
    begin
        regs.crmd_plv       = crmd_plv;
        regs.crmd_ie        = crmd_ie;
        regs.crmd_da        = crmd_da;
        regs.prmd_pplv      = prmd_pplv;
        regs.prmd_pie       = prmd_pie;
        regs.ecfg_lie       = ecfg_lie;
        regs.estat_is_sw    = estat_is_sw;
        regs.estat_ecode    = estat_ecode;
        regs.estat_esubcode = estat_esubcode;
        regs.era            = era;
        regs.eentry         = eentry;
        regs.save           = save;
        regs.tid            = tid;
        regs.tcfg           = tcfg;
        regs.tval           = tval;
        regs.ti             = ti;
    end

endmodule

`default_nettype wire

//--- hw/csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_macros.svh"

module csr_unit (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire csr_pipe_pkg::csr_req_t  req,
    input  wire logic                    op_valid,
    input  wire csr_pipe_pkg::excp_t     excp,
    input  wire logic                    stall,
    input  wire logic                    flush,
    input  wire logic [`HW_IRQ_N-1:0]    hw_irq,
    output wire csr_arch_pkg::csr_data_t rdata,
    output wire logic                    redirect,
    output wire csr_arch_pkg::csr_data_t redirect_pc,
    output wire logic                    excp_flush,
    output wire logic                    ertn_flush,
    output wire csr_arch_pkg::plv_t      crmd_plv,
    output wire logic                    crmd_ie
);

    wire csr_arch_pkg::csr_view_t  regs;
    wire csr_pipe_pkg::csr_stage_t stage;
    wire logic                     tcfg_wr;
    wire csr_arch_pkg::csr_data_t  tcfg;
    wire logic                     ti_clr;
    wire csr_arch_pkg::csr_data_t  tval;
    wire logic                     ti;

    assign crmd_plv = regs.crmd_plv;
    assign crmd_ie  = regs.crmd_ie;

    csr_issue u_issue (
        .clk, .rstn, .req, .op_valid, .excp, .stall, .flush, .hw_irq,
        .regs, .stage, .rdata, .redirect, .redirect_pc
    );

    csr_regfile u_regfile (
        .clk, .rstn, .stage, .tval, .ti, .regs,
        .tcfg_wr, .tcfg, .ti_clr, .excp_flush, .ertn_flush
    );

    csr_timer #(.TIMER_W(32)) u_timer (
        .clk, .rstn, .tcfg_wr, .tcfg, .ti_clr, .tval, .ti
    );

endmodule

`default_nettype wire

//--- test/csr_unit_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit_asserts (
    input wire logic clk,
    input wire logic rstn,
    input wire logic excp_flush,
    input wire logic ertn_flush
);

    // entry and return never commit together
    no_double_flush: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush))
        else $error("excp_flush and ertn_flush high in the same cycle");

    excp_flush_pulse: assert property (@(posedge clk) disable iff (!rstn)
        excp_flush |=> !excp_flush)
        else $error("excp_flush held high for more than one cycle");

    ertn_flush_pulse: assert property (@(posedge clk) disable iff (!rstn)
        ertn_flush |=> !ertn_flush)
        else $error("ertn_flush held high for more than one cycle");

    // sync reset, so flushes are low one edge later
    flush_quiet_in_reset: assert property (@(posedge clk)
        !rstn |=> (!excp_flush && !ertn_flush))
        else $error("flush pulse seen while in reset");

endmodule

bind csr_unit csr_unit_asserts u_asserts (
    .clk(clk),
    .rstn(rstn),
    .excp_flush(excp_flush),
    .ertn_flush(ertn_flush)
);

`default_nettype wire

//--- test/csr_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_macros.svh"

module csr_unit_tb;

    localparam int period     = 40;
    localparam int timer_init = 16;  // word granular like TCFG initval
    localparam int watchdog   = (200 + timer_init) * period;

    logic                    clk;
    logic                    rstn;
    csr_pipe_pkg::csr_req_t  req;
    logic                    op_valid;
    csr_pipe_pkg::excp_t     excp;
    logic                    stall;
    logic                    flush;
    logic [`HW_IRQ_N-1:0]    hw_irq;
    csr_arch_pkg::csr_data_t rdata;
    logic                    redirect;
    csr_arch_pkg::csr_data_t redirect_pc;
    logic                    excp_flush;
    logic                    ertn_flush;
    csr_arch_pkg::plv_t      crmd_plv;
    logic                    crmd_ie;

    csr_arch_pkg::csr_data_t got_rdata;
    logic                    got_redir;
    csr_arch_pkg::csr_data_t got_pc;
    logic                    got_eflush;
    logic                    got_rflush;
    integer                  seed = 17;

    csr_unit dut0 (
        .clk, .rstn, .req, .op_valid, .excp, .stall, .flush, .hw_irq,
        .rdata, .redirect, .redirect_pc, .excp_flush, .ertn_flush, .crmd_plv, .crmd_ie
    );

    initial
    begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial
    begin
        #(watchdog);
        $display("timeout, run went past %0d ns without finishing", watchdog);
        $display("tests failed");
        $fatal(1);
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic set_req(input csr_pipe_pkg::csr_op_e op, input csr_arch_pkg::csr_num_t num,
                           input csr_arch_pkg::csr_data_t wdata,
                           input csr_arch_pkg::csr_data_t wmask,
                           input csr_arch_pkg::csr_data_t pc);
        req.op      = op;
        req.csr_num = num;
        req.wdata   = wdata;
        req.wmask   = wmask;
        req.pc      = pc;
    endtask

    // one op through accept and commit with outputs captured at each edge
    task automatic issue_op(input csr_pipe_pkg::csr_op_e op, input csr_arch_pkg::csr_num_t num,
                            input csr_arch_pkg::csr_data_t wdata,
                            input csr_arch_pkg::csr_data_t wmask,
                            input csr_arch_pkg::csr_data_t pc);
        set_req(op, num, wdata, wmask, pc);
        op_valid = 1'b1;
        next_cycle();
        got_rdata = rdata;
        got_redir = redirect;
        got_pc    = redirect_pc;
        op_valid  = 1'b0;
        excp      = '0;
        next_cycle();
        got_eflush = excp_flush;
        got_rflush = ertn_flush;
    endtask

    task automatic read_csr(input csr_arch_pkg::csr_num_t num,
                            output csr_arch_pkg::csr_data_t data);
        issue_op(csr_pipe_pkg::CSRRD, num, '0, '0, '0);
        data = got_rdata;
    endtask

    initial
    begin
        csr_arch_pkg::csr_data_t val;
        csr_arch_pkg::csr_data_t old_val;
        csr_arch_pkg::csr_data_t mask;
        csr_arch_pkg::csr_data_t rd;
        csr_arch_pkg::csr_data_t pc;
        csr_arch_pkg::csr_data_t eentry_val;
        csr_arch_pkg::csr_data_t excp_pc;
        integer                  wait_cycles;

        rstn     = 1'b0;
        req      = '0;
        op_valid = 1'b0;
        excp     = '0;
        stall    = 1'b0;
        flush    = 1'b0;
        hw_irq   = '0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;

        eentry_val = 32'h1c00_8000;  // 64 byte aligned
        issue_op(csr_pipe_pkg::CSRWR, csr_arch_pkg::EENTRY, eentry_val, '0, 32'h1c00_0000);

        // write then read back
        val = $random(seed);
        pc  = 32'h1c00_0010;
        issue_op(csr_pipe_pkg::CSRWR, csr_arch_pkg::SAVE0, val, '0, pc);
        expect_eq("csrwr_redirect", 32'd1, 32'(got_redir));
        expect_eq("csrwr_redirect_pc", pc + 32'd4, got_pc);
        read_csr(csr_arch_pkg::SAVE0, rd);
        expect_eq("csrrd_no_redirect", 32'd0, 32'(got_redir));
        expect_eq("csrrd_save0", val, rd);

        // masked exchange
        old_val = $random(seed);
        val     = $random(seed);
        mask    = $random(seed);
        issue_op(csr_pipe_pkg::CSRWR, csr_arch_pkg::SAVE1, old_val, '0, pc);
        issue_op(csr_pipe_pkg::CSRXCHG, csr_arch_pkg::SAVE1, val, mask, pc);
        expect_eq("csrxchg_old_value", old_val, got_rdata);
        expect_eq("csrxchg_redirect_pc", pc + 32'd4, got_pc);
        read_csr(csr_arch_pkg::SAVE1, rd);
        expect_eq("csrxchg_merge", (val & mask) | (old_val & ~mask), rd);

        // op held under stall
        old_val = $random(seed);
        val     = $random(seed);
        issue_op(csr_pipe_pkg::CSRWR, csr_arch_pkg::SAVE2, old_val, '0, pc);
        set_req(csr_pipe_pkg::CSRWR, csr_arch_pkg::SAVE2, val, '0, pc);
        op_valid = 1'b1;
        stall    = 1'b1;
        repeat (5)
        begin
            next_cycle();
            expect_eq("stall_redirect", 32'd0, 32'(redirect));
        end
        stall = 1'b0;
        next_cycle();
        expect_eq("stall_release_redirect", 32'd1, 32'(redirect));
        expect_eq("stall_save2_unchanged", old_val, rdata);  // old value as the op goes in
        op_valid = 1'b0;
        next_cycle();
        read_csr(csr_arch_pkg::SAVE2, rd);
        expect_eq("stall_save2_written", val, rd);

        // exception entry from PLV3 with IE set
        issue_op(csr_pipe_pkg::CSRWR, csr_arch_pkg::CRMD, 32'h0000_0007, '0, pc);
        expect_eq("crmd_plv3", 32'd3, 32'(crmd_plv));
        excp_pc       = 32'h1c00_0100;
        excp.valid    = 1'b1;
        excp.ecode    = csr_arch_pkg::SYS;
        excp.esubcode = '0;
        set_req(csr_pipe_pkg::NONE, '0, '0, '0, excp_pc);
        op_valid = 1'b1;
        stall    = 1'b1;
        repeat (3)
        begin
            next_cycle();
            expect_eq("stall_excp_redirect", 32'd0, 32'(redirect));
            expect_eq("stall_excp_flush", 32'd0, 32'(excp_flush));
        end
        stall = 1'b0;
        issue_op(csr_pipe_pkg::NONE, '0, '0, '0, excp_pc);
        expect_eq("excp_redirect", 32'd1, 32'(got_redir));
        expect_eq("excp_redirect_pc", eentry_val, got_pc);
        expect_eq("excp_flush_pulse", 32'd1, 32'(got_eflush));
        expect_eq("excp_crmd_plv", 32'd0, 32'(crmd_plv));
        expect_eq("excp_crmd_ie", 32'd0, 32'(crmd_ie));
        read_csr(csr_arch_pkg::ERA, rd);
        expect_eq("excp_era", excp_pc, rd);
        read_csr(csr_arch_pkg::ESTAT, rd);
        expect_eq("excp_estat_ecode", 32'(csr_arch_pkg::SYS), 32'(rd[21:16]));
        read_csr(csr_arch_pkg::PRMD, rd);
        expect_eq("excp_prmd", 32'h0000_0007, 32'(rd[2:0]));  // pie 1 and pplv 3

        issue_op(csr_pipe_pkg::ERTN, '0, '0, '0, pc);
        expect_eq("ertn_redirect", 32'd1, 32'(got_redir));
        expect_eq("ertn_redirect_pc", excp_pc, got_pc);
        expect_eq("ertn_flush_pulse", 32'd1, 32'(got_rflush));
        expect_eq("ertn_excp_flush", 32'd0, 32'(got_eflush));
        expect_eq("ertn_crmd_plv", 32'd3, 32'(crmd_plv));
        expect_eq("ertn_crmd_ie", 32'd1, 32'(crmd_ie));

        // timer interrupt with IE still set from ERTN
        issue_op(csr_pipe_pkg::CSRWR, csr_arch_pkg::ECFG, 32'h0000_0800, '0, pc);
        issue_op(csr_pipe_pkg::CSRWR, csr_arch_pkg::TCFG, 32'(timer_init) | 32'd1, '0, pc);
        wait_cycles = 0;
        while (!redirect && wait_cycles < timer_init + 10)
        begin
            next_cycle();
            wait_cycles = wait_cycles + 1;
        end
        if (!redirect)
        begin
            $display("timer interrupt was not taken within %0d cycles", timer_init + 10);
            $display("tests failed");
            $fatal(1);
        end
        expect_eq("irq_redirect_pc", eentry_val, redirect_pc);
        next_cycle();
        expect_eq("irq_excp_flush", 32'd1, 32'(excp_flush));
        expect_eq("irq_crmd_ie", 32'd0, 32'(crmd_ie));
        read_csr(csr_arch_pkg::ESTAT, rd);
        expect_eq("irq_estat_ti", 32'd1, 32'(rd[11]));
        expect_eq("irq_estat_ecode", 32'(csr_arch_pkg::INT), 32'(rd[21:16]));
        issue_op(csr_pipe_pkg::CSRWR, csr_arch_pkg::TICLR, 32'd1, '0, pc);
        next_cycle();  // clear strobe reaches the timer
        read_csr(csr_arch_pkg::ESTAT, rd);
        expect_eq("ticlr_estat_ti", 32'd0, 32'(rd[11]));

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/csr_arch_pkg.sv
hw/csr_pipe_pkg.sv
hw/csr_timer.sv
hw/csr_issue.sv
hw/csr_regfile.sv
hw/csr_unit.sv
test/csr_unit_asserts.sv
test/csr_unit_tb.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module csr_unit_tb -o csr_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/csr_sim > sim.log 2>&1 || echo "tests failed" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
